// ==== rtl/motor_link_pkg.sv ====
// Motor link package with the widths, command codes, watchdog limits and the stage bundles
package motor_link_pkg;

    // Sizes
    localparam int NUM_MOTORS     = 4;
    localparam int BYTE_W         = 8;
    localparam int DUTY_W         = 10;
    localparam int ENC_W          = 16;
    localparam int WDT_PRESCALE_W = 4;
    localparam int WDT_W          = 8;
    localparam int BUF_LEN        = 12;
    localparam int CNT_W          = 4;

    // Plain vector types
    typedef logic [BYTE_W-1:0]   byte_t;
    typedef logic [DUTY_W-1:0]   duty_t;
    typedef logic [ENC_W-1:0]    enc_count_t;
    typedef logic [WDT_W-1:0]    wdt_count_t;
    typedef logic [BYTE_W-2:0]   cmd_code_t;

    // Filler for unknown commands and unused reply bytes
    localparam byte_t RESP_FILL = 8'hAA;

    // Watchdog terminal count, in prescaled ticks
    localparam wdt_count_t WDT_LIMIT = 8'hFF;

    // Command codes, low 7 bits of the command byte
    localparam cmd_code_t CMD_UPDATE_MTRS     = 7'h00;
    localparam cmd_code_t CMD_ENCODER_COUNT   = 7'h11;
    localparam cmd_code_t CMD_DUTY_CYCLE      = 7'h13;
    localparam cmd_code_t CMD_TOGGLE_MOTOR_EN = 7'h20;
    // Command byte MSB value for a read
    localparam logic      CMD_READ_TYPE       = 1'b1;

    // Byte link events, all strobes one sysclk wide
    typedef struct packed {
        logic  start;
        logic  byte_done;
        logic  frame_end;
        byte_t rx_byte;
    } link_evt_t;

    typedef struct packed {
        duty_t [NUM_MOTORS-1:0] duty;
    } duty_vec_t;

    typedef struct packed {
        enc_count_t [NUM_MOTORS-1:0] cnt;
    } enc_vec_t;

    // Decoded request for the motor guard
    typedef struct packed {
        logic      apply_duty;
        duty_vec_t duties;
        logic      en_set;
        logic      en_clr;
    } motor_cmd_t;

    // Decoder frame phase
    typedef enum logic [1:0] {
        IDLE,
        CMD,
        DATA
    } link_phase_e;

endpackage

// ==== rtl/spi_byte_link.sv ====
// SPI mode 0 slave byte link with pin synchronizers, byte shifters and frame strobes
module spi_byte_link (
    input  logic                      sysclk,
    input  logic                      watchdog_timer_reset_flag,
    input  logic                      sck_i,
    input  logic                      mosi_i,
    input  logic                      ncs_i,
    input  motor_link_pkg::byte_t     tx_byte_i,
    output motor_link_pkg::link_evt_t evt_o,
    output logic                      miso_o
);
    import motor_link_pkg::*;

    // Two flop synchronizers, bit 1 is the synced value
    logic [1:0] sck_sync;
    logic [1:0] mosi_sync;
    logic [1:0] ncs_sync;
    // Delayed copies for edge detection
    logic       sck_d;
    logic       ncs_d;
    logic       sck_rise;
    logic       sck_fall;
    logic       ncs_fall;
    logic       ncs_rise;
    logic       active;
    // Bit position inside the current byte, wraps every 8 bits
    logic [2:0] bit_cnt;
    byte_t      rx_sh;
    byte_t      tx_sh;

    assign active   = ~ncs_sync[1];
    assign sck_rise = sck_sync[1] & ~sck_d & active;
    assign sck_fall = ~sck_sync[1] & sck_d & active;
    assign ncs_fall = ~ncs_sync[1] & ncs_d;
    assign ncs_rise = ncs_sync[1] & ~ncs_d;

    // MSB first
    assign miso_o = tx_sh[BYTE_W-1];

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            sck_sync  <= '0;
            mosi_sync <= '0;
            // Select idles high, so no false edge leaving reset
            ncs_sync  <= '1;
            sck_d     <= 1'b0;
            ncs_d     <= 1'b1;
            bit_cnt   <= '0;
            rx_sh     <= '0;
            tx_sh     <= '0;
            evt_o     <= '0;
        end else begin
            sck_sync  <= {sck_sync[0], sck_i};
            mosi_sync <= {mosi_sync[0], mosi_i};
            ncs_sync  <= {ncs_sync[0], ncs_i};
            sck_d     <= sck_sync[1];
            ncs_d     <= ncs_sync[1];

            evt_o.start     <= ncs_fall;
            evt_o.frame_end <= ncs_rise;
            evt_o.byte_done <= sck_rise && (bit_cnt == 3'd7);

            // Host drives MOSI on the falling edge, sample on the rising one
            if (sck_rise) begin
                rx_sh   <= {rx_sh[BYTE_W-2:0], mosi_sync[1]};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    evt_o.rx_byte <= {rx_sh[BYTE_W-2:0], mosi_sync[1]};
                end
            end

            if (ncs_fall) begin
                // First byte must sit on MISO before the first rising edge
                bit_cnt <= '0;
                tx_sh   <= tx_byte_i;
            end else if (sck_fall) begin
                // Wrapped count means a byte just finished, take the next one
                if (bit_cnt == 3'd0) begin
                    tx_sh <= tx_byte_i;
                end else begin
                    tx_sh <= {tx_sh[BYTE_W-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== rtl/quad_encoder_bank.sv ====
// Quadrature encoder bank with one synchronized decoder and up/down counter per motor
module quad_encoder_bank (
    input  logic                                    sysclk,
    input  logic                                    watchdog_timer_reset_flag,
    input  logic [motor_link_pkg::NUM_MOTORS-1:0]   enc_a_i,
    input  logic [motor_link_pkg::NUM_MOTORS-1:0]   enc_b_i,
    input  logic                                    clr_i,
    output motor_link_pkg::enc_vec_t                counts_o
);
    import motor_link_pkg::*;

    // A/B pairs, {a, b}, through two sync stages plus the previous sample
    logic [1:0] ab_meta [NUM_MOTORS];
    logic [1:0] ab_sync [NUM_MOTORS];
    logic [1:0] ab_prev [NUM_MOTORS];

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            for (int m = 0; m < NUM_MOTORS; m++) begin
                ab_meta[m] <= '0;
                ab_sync[m] <= '0;
                ab_prev[m] <= '0;
            end
            counts_o <= '0;
        end else begin
            for (int m = 0; m < NUM_MOTORS; m++) begin
                ab_meta[m] <= {enc_a_i[m], enc_b_i[m]};
                ab_sync[m] <= ab_meta[m];
                ab_prev[m] <= ab_sync[m];
                if (clr_i) begin
                    counts_o.cnt[m] <= '0;
                // Exactly one phase changed, double changes are dropped
                end else if (^(ab_sync[m] ^ ab_prev[m])) begin
                    // New A differs from old B when A leads
                    if (ab_sync[m][1] ^ ab_prev[m][0]) begin
                        counts_o.cnt[m] <= counts_o.cnt[m] + 1'b1;
                    end else begin
                        counts_o.cnt[m] <= counts_o.cnt[m] - 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/frame_decoder.sv ====
// Frame decoder that buffers request bytes, decodes commands and loads the reply bytes
module frame_decoder (
    input  logic                       sysclk,
    input  logic                       watchdog_timer_reset_flag,
    input  motor_link_pkg::link_evt_t  evt_i,
    input  motor_link_pkg::enc_vec_t   enc_i,
    input  motor_link_pkg::duty_vec_t  duties_i,
    input  logic                       motors_en_i,
    input  logic                       wdt_tripped_i,
    output motor_link_pkg::byte_t      tx_byte_o,
    output motor_link_pkg::motor_cmd_t cmd_o,
    output logic                       enc_clr_o
);
    import motor_link_pkg::*;

    link_phase_e      state;
    // Bytes received in this frame, command byte included
    logic [CNT_W-1:0] byte_cnt;
    byte_t            req_buf  [BUF_LEN];
    byte_t            resp_buf [BUF_LEN];
    logic             upd_ok;
    logic             tog_ok;
    logic             apply_q;
    logic             set_q;
    logic             clr_q;
    duty_vec_t        duty_q;

    // Frame end checks, command byte sits in slot 0
    assign upd_ok = (req_buf[0][BYTE_W-2:0] == CMD_UPDATE_MTRS) &&
                    (req_buf[0][BYTE_W-1] == CMD_READ_TYPE) &&
                    (byte_cnt == CNT_W'(2 * NUM_MOTORS + 1));
    assign tog_ok = (req_buf[0][BYTE_W-2:0] == CMD_TOGGLE_MOTOR_EN) &&
                    (byte_cnt == CNT_W'(1));

    assign cmd_o     = '{apply_duty: apply_q, duties: duty_q, en_set: set_q, en_clr: clr_q};
    // Counts were taken with the command byte, safe to clear now
    assign enc_clr_o = apply_q;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            state    <= IDLE;
            byte_cnt <= '0;
            apply_q  <= 1'b0;
            set_q    <= 1'b0;
            clr_q    <= 1'b0;
        end else begin
            apply_q <= 1'b0;
            set_q   <= 1'b0;
            clr_q   <= 1'b0;
            if (evt_i.start) begin
                state    <= CMD;
                byte_cnt <= '0;
            end else if (evt_i.frame_end) begin
                // Back to zero so the status byte is ready for the next frame
                state    <= IDLE;
                byte_cnt <= '0;
                if (state == DATA) begin
                    apply_q <= upd_ok;
                    set_q   <= tog_ok && (req_buf[0][BYTE_W-1] == CMD_READ_TYPE);
                    clr_q   <= tog_ok && (req_buf[0][BYTE_W-1] != CMD_READ_TYPE);
                end
            end else if (evt_i.byte_done && (state != IDLE)) begin
                state <= DATA;
                // Saturate on overlong frames
                if (byte_cnt != '1) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        // Status byte, refreshed every cycle
        resp_buf[0] <= {motors_en_i, wdt_tripped_i, {(BYTE_W-2){1'b0}}};

        if (evt_i.byte_done && (state != IDLE)) begin
            if (byte_cnt < BUF_LEN) begin
                req_buf[byte_cnt] <= evt_i.rx_byte;
            end
            // Command byte landed, snapshot the reply
            if (state == CMD) begin
                for (int i = 1; i < BUF_LEN; i++) begin
                    resp_buf[i] <= RESP_FILL;
                end
                if (evt_i.rx_byte[BYTE_W-1] == CMD_READ_TYPE) begin
                    case (evt_i.rx_byte[BYTE_W-2:0])
                        CMD_UPDATE_MTRS, CMD_ENCODER_COUNT: begin
                            for (int j = 0; j < NUM_MOTORS; j++) begin
                                resp_buf[2*j+1] <= enc_i.cnt[j][ENC_W-1:BYTE_W];
                                resp_buf[2*j+2] <= enc_i.cnt[j][BYTE_W-1:0];
                            end
                        end
                        CMD_DUTY_CYCLE: begin
                            for (int j = 0; j < NUM_MOTORS; j++) begin
                                resp_buf[2*j+1] <= BYTE_W'(duties_i.duty[j][DUTY_W-1:BYTE_W]);
                                resp_buf[2*j+2] <= duties_i.duty[j][BYTE_W-1:0];
                            end
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end

        // Duty bytes arrive low then high, one pair per motor
        if (evt_i.frame_end) begin
            for (int j = 0; j < NUM_MOTORS; j++) begin
                duty_q.duty[j] <= {req_buf[2*j+2][DUTY_W-BYTE_W-1:0], req_buf[2*j+1]};
            end
        end

        // Registered, so the next byte is ready 2 cycles after byte_done
        tx_byte_o <= (byte_cnt < BUF_LEN) ? resp_buf[byte_cnt] : RESP_FILL;
    end

endmodule

// ==== rtl/motor_guard.sv ====
// Motor guard with the duty registers, the enable level and the prescaled watchdog
module motor_guard (
    input  logic                       sysclk,
    input  logic                       watchdog_timer_reset_flag,
    input  motor_link_pkg::motor_cmd_t cmd_i,
    output motor_link_pkg::duty_vec_t  duty_o,
    output motor_link_pkg::duty_vec_t  duties_o,
    output logic                       motors_en_o,
    output logic                       wdt_tripped_o
);
    import motor_link_pkg::*;

    duty_vec_t                 duty_q;
    logic                      en_q;
    logic                      tripped_q;
    logic                      kick;
    logic                      wdt_tick;
    logic [WDT_PRESCALE_W-1:0] presc;
    wdt_count_t                wdt_cnt;

    // Any accepted host command keeps the watchdog fed
    assign kick     = cmd_i.apply_duty | cmd_i.en_set | cmd_i.en_clr;
    // One tick per prescaler wrap
    assign wdt_tick = (presc == '1);

    assign duties_o      = duty_q;
    // Disabled motors see zero duty
    assign duty_o        = en_q ? duty_q : '0;
    assign motors_en_o   = en_q;
    assign wdt_tripped_o = tripped_q;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            duty_q    <= '0;
            en_q      <= 1'b1;
            tripped_q <= 1'b0;
            presc     <= '0;
            wdt_cnt   <= '0;
        end else begin
            if (cmd_i.apply_duty) begin
                duty_q <= cmd_i.duties;
            end

            // Kick restarts both counters and clears a trip
            if (kick) begin
                presc     <= '0;
                wdt_cnt   <= '0;
                tripped_q <= 1'b0;
            end else begin
                presc <= presc + 1'b1;
                // Count stops once tripped
                if (wdt_tick && !tripped_q) begin
                    wdt_cnt <= wdt_cnt + 1'b1;
                    if (wdt_cnt == WDT_LIMIT - 1'b1) begin
                        tripped_q <= 1'b1;
                    end
                end
            end

            // New duties or an explicit enable win over a pending trip
            if (cmd_i.apply_duty || cmd_i.en_set) begin
                en_q <= 1'b1;
            end else if (cmd_i.en_clr || tripped_q) begin
                en_q <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/motor_link_top.sv ====
// Motor link top level joining the SPI byte link, frame decoder, motor guard and encoders
module motor_link_top (
    input  logic                                  sysclk,
    input  logic                                  watchdog_timer_reset_flag,
    input  logic                                  spi_sck_i,
    input  logic                                  spi_mosi_i,
    input  logic                                  spi_ncs_i,
    output logic                                  spi_miso_o,
    input  logic [motor_link_pkg::NUM_MOTORS-1:0] enc_a_i,
    input  logic [motor_link_pkg::NUM_MOTORS-1:0] enc_b_i,
    output motor_link_pkg::duty_vec_t             duty_o,
    output logic                                  motors_en_o,
    output logic                                  wdt_tripped_o
);
    import motor_link_pkg::*;

    link_evt_t  evt;
    byte_t      tx_byte;
    motor_cmd_t motor_cmd;
    logic       enc_clr;
    enc_vec_t   enc_counts;
    // Ungated duties for readback
    duty_vec_t  duties;

    spi_byte_link u_link (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .sck_i                     (spi_sck_i),
        .mosi_i                    (spi_mosi_i),
        .ncs_i                     (spi_ncs_i),
        .tx_byte_i                 (tx_byte),
        .evt_o                     (evt),
        .miso_o                    (spi_miso_o)
    );

    frame_decoder u_dec (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .evt_i                     (evt),
        .enc_i                     (enc_counts),
        .duties_i                  (duties),
        .motors_en_i               (motors_en_o),
        .wdt_tripped_i             (wdt_tripped_o),
        .tx_byte_o                 (tx_byte),
        .cmd_o                     (motor_cmd),
        .enc_clr_o                 (enc_clr)
    );

    motor_guard u_guard (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .cmd_i                     (motor_cmd),
        .duty_o                    (duty_o),
        .duties_o                  (duties),
        .motors_en_o               (motors_en_o),
        .wdt_tripped_o             (wdt_tripped_o)
    );

    quad_encoder_bank u_enc (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .enc_a_i                   (enc_a_i),
        .enc_b_i                   (enc_b_i),
        .clr_i                     (enc_clr),
        .counts_o                  (enc_counts)
    );

endmodule

// ==== verification/motor_link_chk.sv ====
// Motor link checker with assertions on the link strobes, enable commands and watchdog trip
module motor_link_chk (
    input logic                       sysclk,
    input logic                       watchdog_timer_reset_flag,
    input motor_link_pkg::link_evt_t  evt_i,
    input motor_link_pkg::motor_cmd_t cmd_i,
    input logic                       motors_en_i,
    input logic                       wdt_tripped_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // A byte cannot complete in the cycle the frame opens
    start_vs_byte: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        !(evt_i.start && evt_i.byte_done))
        else $error("byte_done and start strobes high in the same cycle");

    // Disable strobe turns the motors off on the next cycle
    clr_disables: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        cmd_i.en_clr |=> !motors_en_i)
        else $error("motors still enabled one cycle after an enable clear");

    // Trip drops the enable next cycle, unless the host re-enables right then
    trip_disables: assert property (@(posedge sysclk) disable iff (watchdog_timer_reset_flag)
        (wdt_tripped_i && !cmd_i.apply_duty && !cmd_i.en_set) |=> !motors_en_i)
        else $error("motors still enabled one cycle after a watchdog trip");

endmodule

bind motor_link_top motor_link_chk u_chk (
    .sysclk                    (sysclk),
    .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
    .evt_i                     (evt),
    .cmd_i                     (motor_cmd),
    .motors_en_i               (motors_en_o),
    .wdt_tripped_i             (wdt_tripped_o)
);

// ==== verification/motor_link_tb.sv ====
// Motor link testbench that replays the test file over SPI and the encoder pins
module motor_link_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import motor_link_pkg::*;

    localparam string TEST_FILE = "verification/motor_link_tests.txt";
    localparam int    HALF_SCK  = 4;
    localparam int    BYTE_GAP  = 8;
    localparam int    MAX_BYTES = 16;

    logic                  sysclk;
    logic                  watchdog_timer_reset_flag;
    logic                  spi_sck;
    logic                  spi_mosi;
    logic                  spi_ncs;
    logic                  spi_miso;
    logic [NUM_MOTORS-1:0] enc_a;
    logic [NUM_MOTORS-1:0] enc_b;
    duty_vec_t             duty;
    logic                  motors_en;
    logic                  wdt_tripped;

    // Parsed operations, their arguments in file order
    byte   op_q  [$];
    int    arg_q [$];
    int    budget     = 500;
    logic  budget_set = 1'b0;
    // Quadrature phase index per motor
    int    phase [NUM_MOTORS];
    byte_t req_bytes [MAX_BYTES];
    byte_t rsp_bytes [MAX_BYTES];
    byte_t exp_bytes [MAX_BYTES];

    motor_link_top u_dut (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .spi_sck_i                 (spi_sck),
        .spi_mosi_i                (spi_mosi),
        .spi_ncs_i                 (spi_ncs),
        .spi_miso_o                (spi_miso),
        .enc_a_i                   (enc_a),
        .enc_b_i                   (enc_b),
        .duty_o                    (duty),
        .motors_en_o               (motors_en),
        .wdt_tripped_o             (wdt_tripped)
    );

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    task automatic stop_on_error();
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_duty(input duty_vec_t got, input duty_vec_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s got %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // Forward order of {A, B}, A leads B by a quarter cycle
    function automatic logic [1:0] quad_phase(input int idx);
        case (idx)
            0:       return 2'b00;
            1:       return 2'b10;
            2:       return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    // One transition every 4 cycles
    task automatic move_encoder(input int motor, input int steps, input int dir);
        logic [1:0] ab;
        for (int s = 0; s < steps; s++) begin
            @(posedge sysclk);
            phase[motor] = dir ? (phase[motor] + 1) % 4 : (phase[motor] + 3) % 4;
            ab = quad_phase(phase[motor]);
            enc_a[motor] <= ab[1];
            enc_b[motor] <= ab[0];
            repeat (3) @(posedge sysclk);
        end
    endtask

    // Mode 0 frame, MISO taken just before each rising SCK
    task automatic spi_transfer(input int n);
        byte_t rx;
        @(posedge sysclk);
        spi_ncs <= 1'b0;
        repeat (8) @(posedge sysclk);
        for (int k = 0; k < n; k++) begin
            rx = '0;
            for (int i = BYTE_W - 1; i >= 0; i--) begin
                spi_mosi <= req_bytes[k][i];
                repeat (HALF_SCK - 1) @(posedge sysclk);
                @(negedge sysclk);
                rx[i] = spi_miso;
                @(posedge sysclk);
                spi_sck <= 1'b1;
                repeat (HALF_SCK) @(posedge sysclk);
                spi_sck <= 1'b0;
            end
            rsp_bytes[k] = rx;
            // Gap lets the decoder queue the next reply byte
            repeat (BYTE_GAP) @(posedge sysclk);
        end
        spi_ncs  <= 1'b1;
        spi_mosi <= 1'b0;
        repeat (10) @(posedge sysclk);
    endtask

    task automatic read_values(input int fd, input int count, input bit hex);
        int v;
        int code;
        for (int i = 0; i < count; i++) begin
            if (hex) begin
                code = $fscanf(fd, "%h", v);
            end else begin
                code = $fscanf(fd, "%d", v);
            end
            if (code != 1) begin
                $display("The test file ends early or holds a value that cannot be read");
                stop_on_error();
            end else begin
                arg_q.push_back(v);
            end
        end
    endtask

    // Ends the run once the cycle budget of the test file is used up
    initial begin
        wait (budget_set);
        repeat (budget) @(posedge sysclk);
        $display("Run timed out after %0d clock cycles without finishing the tests", budget);
        stop_on_error();
    end

    initial begin
        int        fd;
        int        c;
        int        n;
        int        m;
        int        d;
        int        frame_no;
        byte       op;
        duty_vec_t exp_duty;
        logic      exp_en;
        logic      exp_trip;

        watchdog_timer_reset_flag <= 1'b1;
        spi_sck   <= 1'b0;
        spi_mosi  <= 1'b0;
        spi_ncs   <= 1'b1;
        enc_a     <= '0;
        enc_b     <= '0;
        frame_no  = 0;
        for (int j = 0; j < NUM_MOTORS; j++) begin
            phase[j] = 0;
        end

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", TEST_FILE);
            stop_on_error();
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                case (op)
                    "#": begin
                        c = $fgetc(fd);
                        while (c != "\n" && c != -1) begin
                            c = $fgetc(fd);
                        end
                    end
                    "E": begin
                        read_values(fd, 3, 1'b0);
                        budget += 4 * arg_q[arg_q.size() - 2] + 8;
                    end
                    "F": begin
                        read_values(fd, 1, 1'b0);
                        n = arg_q[arg_q.size() - 1];
                        if (n < 1 || n > MAX_BYTES) begin
                            $display("Frame length %0d in the test file is out of range", n);
                            stop_on_error();
                        end else begin
                            read_values(fd, 2 * n, 1'b1);
                            budget += n * (2 * HALF_SCK * BYTE_W + BYTE_GAP) + 20;
                        end
                    end
                    "W": begin
                        read_values(fd, 1, 1'b0);
                        budget += arg_q[arg_q.size() - 1];
                    end
                    "C": begin
                        read_values(fd, NUM_MOTORS + 2, 1'b1);
                        budget += 2;
                    end
                    default: begin
                        $display("Unknown operation '%c' in the test file", op);
                        stop_on_error();
                    end
                endcase
                if (op != "#") begin
                    op_q.push_back(op);
                end
            end
            $fclose(fd);
        end
        budget_set = 1'b1;

        // Reset held for 5 cycles
        repeat (5) @(posedge sysclk);
        watchdog_timer_reset_flag <= 1'b0;

        while (op_q.size() > 0) begin
            op = op_q.pop_front();
            case (op)
                "E": begin
                    m = arg_q.pop_front();
                    n = arg_q.pop_front();
                    d = arg_q.pop_front();
                    move_encoder(m, n, d);
                end
                "F": begin
                    n = arg_q.pop_front();
                    for (int k = 0; k < n; k++) begin
                        req_bytes[k] = byte_t'(arg_q.pop_front());
                    end
                    for (int k = 0; k < n; k++) begin
                        exp_bytes[k] = byte_t'(arg_q.pop_front());
                    end
                    spi_transfer(n);
                    frame_no++;
                    for (int k = 0; k < n; k++) begin
                        check_byte(rsp_bytes[k], exp_bytes[k],
                                   $sformatf("frame %0d response byte %0d", frame_no, k));
                    end
                end
                "W": begin
                    n = arg_q.pop_front();
                    repeat (n) @(posedge sysclk);
                end
                default: begin
                    for (int j = 0; j < NUM_MOTORS; j++) begin
                        exp_duty.duty[j] = duty_t'(arg_q.pop_front());
                    end
                    m        = arg_q.pop_front();
                    exp_en   = m[0];
                    m        = arg_q.pop_front();
                    exp_trip = m[0];
                    // Outputs are settled mid-cycle
                    @(negedge sysclk);
                    check_duty(duty, exp_duty, "duty_o");
                    check_flag(motors_en, exp_en, "motors_en_o");
                    check_flag(wdt_tripped, exp_trip, "wdt_tripped_o");
                end
            endcase
        end

        @(posedge sysclk);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== motor_link.f ====
rtl/motor_link_pkg.sv
rtl/spi_byte_link.sv
rtl/quad_encoder_bank.sv
rtl/frame_decoder.sv
rtl/motor_guard.sv
rtl/motor_link_top.sv
verification/motor_link_chk.sv
verification/motor_link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the motor link testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f motor_link.f --top-module motor_link_tb -o motor_link_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/motor_link_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// ==== verification/motor_link_tests.txt ====
# E motor steps dir (1 forward, 0 reverse) | W idle cycles, both decimal
# F count, request bytes, expected response bytes | C duty0..duty3 motors_en wdt_tripped, hex
C 000 000 000 000 1 0
F 4 FF 00 00 00  80 AA AA AA
F 3 11 00 00  80 AA AA
F 9 80 23 01 FF 03 55 00 00 02  80 00 00 00 00 00 00 00 00
C 123 3FF 055 200 1 0
F 9 93 00 00 00 00 00 00 00 00  80 01 23 03 FF 00 55 02 00
F 8 80 11 00 11 00 11 00 11  80 00 00 00 00 00 00 00
C 123 3FF 055 200 1 0
E 0 5 1
E 1 3 0
E 2 7 1
E 2 2 0
E 3 1 1
F 9 91 00 00 00 00 00 00 00 00  80 00 05 FF FD 00 05 00 01
F 9 80 23 01 FF 03 55 00 00 02  80 00 05 FF FD 00 05 00 01
F 9 91 00 00 00 00 00 00 00 00  80 00 00 00 00 00 00 00 00
F 1 20  80
C 000 000 000 000 0 0
F 1 A0  00
C 123 3FF 055 200 1 0
W 4200
C 000 000 000 000 0 1
F 3 FF 00 00  40 AA AA
F 9 80 23 01 FF 03 55 00 00 02  40 00 00 00 00 00 00 00 00
C 123 3FF 055 200 1 0
